// ==== all.f ====
src/rv32i_types_pkg.sv
src/mem_stage.sv
src/wb_stage.sv
src/regfile.sv
src/backend_top.sv
dv/backend_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_backend

sources:
  - src/rv32i_types_pkg.sv
  - src/mem_stage.sv
  - src/wb_stage.sv
  - src/regfile.sv
  - src/backend_top.sv
  - target: test
    files:
      - dv/backend_tb.sv

// ==== dv/backend_tb.sv ====
`timescale 1ns/10ps

module backend_tb;

    import rv32i_types_pkg::*;

    localparam int num_tests = 23;
    localparam logic [6:0] op_alu = 7'b0110011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_ld  = 7'b0000011;
    localparam logic [6:0] op_st  = 7'b0100011;
    localparam logic [6:0] op_br  = 7'b1100011;

    logic clk = 1'b0;
    logic rst;
    logic ex_valid, ex_br_en, ex_mem_read, ex_mem_write, ex_regf_we, ex_ready;
    logic [31:0] ex_inst, ex_pc, ex_alu_out, ex_u_imm, ex_rs2_v;
    logic [4:0] ex_rd_s, rs1_s, rs2_s, retire_rd_s;
    load_ops_t ex_load_ops;
    store_ops_t ex_store_ops;
    regf_m_sel_t ex_regf_m_sel;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata, rs1_v, rs2_v, retire_rd_v;
    logic [3:0] dmem_rmask, dmem_wmask;
    logic dmem_resp, retire_valid;

    // stimulus table
    string names [num_tests];
    logic [6:0] t_opc [num_tests];
    logic [4:0] t_rd [num_tests];
    logic [31:0] t_alu [num_tests];
    logic t_br [num_tests];
    logic [31:0] t_uimm [num_tests];
    logic [31:0] t_rs2 [num_tests];
    load_ops_t t_lop [num_tests];
    store_ops_t t_sop [num_tests];
    regf_m_sel_t t_sel [num_tests];
    logic [31:0] t_exp [num_tests];
    int acc_cyc [num_tests];
    int n_add = 0;

    logic [31:0] mem [256];
    logic [31:0] ref_regs [32];
    logic [3:0] last_wmask;
    logic [31:0] last_wdata;
    logic [3:0] last_rmask;
    logic [31:0] last_addr;
    int resp_cyc = 0;
    int exp_q [$];
    int seed = 32'ha4a0_af66;
    int cycle = 0;
    int retired = 0;
    int passed = 0;
    int failed = 0;
    int other_errs = 0;
    int cnt;
    logic busy;
    logic chk_pend;
    string chk_name;

    backend_top dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle++;

    // **************************************************
    // table setup
    // **************************************************
    task automatic add_op(input string nm, input logic [6:0] opc, input logic [4:0] rd,
                          input logic [31:0] alu, input logic br, input logic [31:0] uimm,
                          input logic [31:0] rs2, input load_ops_t lop, input store_ops_t sop,
                          input regf_m_sel_t sel, input logic [31:0] exp_v);
        names[n_add] = nm;
        t_opc[n_add] = opc;
        t_rd[n_add] = rd;
        t_alu[n_add] = alu;
        t_br[n_add] = br;
        t_uimm[n_add] = uimm;
        t_rs2[n_add] = rs2;
        t_lop[n_add] = lop;
        t_sop[n_add] = sop;
        t_sel[n_add] = sel;
        t_exp[n_add] = exp_v;
        n_add++;
    endtask

    task automatic build_table();
        add_op("alu_out", op_alu, 1, 32'h1234_5678, 0, 0, 0, lw_mem, sw_mem, alu_out_wb,
               32'h1234_5678);
        add_op("br_en", op_alu, 2, 0, 1, 0, 0, lw_mem, sw_mem, br_en_wb, 32'h1);
        add_op("lui", op_lui, 3, 0, 0, 32'habcd_e000, 0, lw_mem, sw_mem, u_imm_wb,
               32'habcd_e000);
        add_op("jal_link", op_jal, 4, 0, 0, 0, 0, lw_mem, sw_mem, pc_plus4_wb, 32'h1010);
        add_op("lb_b0", op_ld, 5, 32'h10, 0, 0, 0, lb_mem, sw_mem, lb_wb, 32'h58);
        add_op("lbu_b1", op_ld, 6, 32'h11, 0, 0, 0, lbu_mem, sw_mem, lbu_wb, 32'h69);
        add_op("lb_b2", op_ld, 7, 32'h12, 0, 0, 0, lb_mem, sw_mem, lb_wb, 32'h7a);
        add_op("lb_b3", op_ld, 8, 32'h13, 0, 0, 0, lb_mem, sw_mem, lb_wb, 32'hffff_ff8b);
        add_op("lbu_b3", op_ld, 9, 32'h13, 0, 0, 0, lbu_mem, sw_mem, lbu_wb, 32'h8b);
        add_op("lh_h0", op_ld, 10, 32'h10, 0, 0, 0, lh_mem, sw_mem, lh_wb, 32'h6958);
        add_op("lh_h1", op_ld, 11, 32'h12, 0, 0, 0, lh_mem, sw_mem, lh_wb, 32'hffff_8b7a);
        add_op("lhu_h1", op_ld, 12, 32'h12, 0, 0, 0, lhu_mem, sw_mem, lhu_wb, 32'h8b7a);
        add_op("lw", op_ld, 13, 32'h10, 0, 0, 0, lw_mem, sw_mem, lw_wb, 32'h8b7a_6958);
        add_op("sb_b1", op_st, 14, 32'h21, 0, 0, 32'hffff_ffa5, lw_mem, sb_mem, alu_out_wb,
               32'h21);
        add_op("sh_h1", op_st, 15, 32'h22, 0, 0, 32'h5555_1234, lw_mem, sh_mem, alu_out_wb,
               32'h22);
        add_op("sw", op_st, 16, 32'h24, 0, 0, 32'hdead_beef, lw_mem, sw_mem, alu_out_wb,
               32'h24);
        add_op("lw_back", op_ld, 17, 32'h20, 0, 0, 0, lw_mem, sw_mem, lw_wb, 32'h1234_a554);
        add_op("lh_back", op_ld, 18, 32'h20, 0, 0, 0, lh_mem, sw_mem, lh_wb, 32'hffff_a554);
        add_op("lbu_back", op_ld, 19, 32'h23, 0, 0, 0, lbu_mem, sw_mem, lbu_wb, 32'h12);
        add_op("lw_sw_back", op_ld, 20, 32'h24, 0, 0, 0, lw_mem, sw_mem, lw_wb, 32'hdead_beef);
        add_op("beq", op_br, 21, 0, 1, 0, 0, lw_mem, sw_mem, br_en_wb, 32'h1);
        add_op("x0_write", op_alu, 0, 32'hffff_ffff, 0, 0, 0, lw_mem, sw_mem, alu_out_wb,
               32'hffff_ffff);
        add_op("alu_after_load", op_alu, 22, 32'h0bad_cafe, 0, 0, 0, lw_mem, sw_mem,
               alu_out_wb, 32'h0bad_cafe);
    endtask

    function automatic logic [4:0] dest_of(input int idx);
        if (t_opc[idx] == op_br || t_opc[idx] == op_st) begin
            return 5'd0;  // no rd for branches and stores
        end
        return t_rd[idx];
    endfunction

    function automatic logic [3:0] store_mask(input int idx);
        logic [1:0] off;
        off = t_alu[idx][1:0];
        case (t_sop[idx])
            sb_mem:  return 4'b0001 << off;
            sh_mem:  return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic check_regs(input string when);
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rs2_s = r[4:0];
            #1;
            if (rs2_v !== ref_regs[r]) begin
                $display("Mismatch %s x%0d expected %h actual %h", when, r, ref_regs[r], rs2_v);
                other_errs++;
            end
        end
    endtask

    // **************************************************
    // data memory model
    // **************************************************
    always @(negedge clk) begin
        logic [7:0] widx;
        if (rst) begin
            dmem_resp = 1'b0;
            busy = 1'b0;
        end else if (dmem_resp) begin
            dmem_resp = 1'b0;  // request drops after this edge
            busy = 1'b0;
        end else if ((dmem_rmask | dmem_wmask) != 4'b0) begin
            if (ex_ready) begin
                $display("ex_ready is high while a memory request is outstanding");
                other_errs++;
            end
            if (!busy) begin
                busy = 1'b1;
                cnt = $random(seed) & 3;  // 1 to 4 cycles
            end else if (cnt > 0) begin
                cnt--;
            end
            if (cnt == 0) begin
                widx = dmem_addr[9:2];
                dmem_rdata = mem[widx];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wmask[b]) mem[widx][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
                last_wmask = dmem_wmask;
                last_wdata = dmem_wdata;
                last_rmask = dmem_rmask;
                last_addr = dmem_addr;
                resp_cyc = cycle + 1;  // count after the response edge
                dmem_resp = 1'b1;
            end
        end
    end

    // **************************************************
    // retire monitor
    // **************************************************
    always @(negedge clk) begin
        int idx;
        logic bad;
        if (chk_pend) begin
            chk_pend = 1'b0;
            if (rs1_v !== ref_regs[rs1_s]) begin
                $display("Mismatch %s readback x%0d expected %h actual %h",
                         chk_name, rs1_s, ref_regs[rs1_s], rs1_v);
                other_errs++;
            end
        end
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("retire seen with no instruction outstanding");
                other_errs++;
            end else begin
                idx = exp_q.pop_front();
                bad = 1'b0;
                if (retire_rd_s !== dest_of(idx)) begin
                    $display("Mismatch %s rd expected %0d actual %0d",
                             names[idx], dest_of(idx), retire_rd_s);
                    bad = 1'b1;
                end
                if (retire_rd_v !== t_exp[idx]) begin
                    $display("Mismatch %s value expected %h actual %h",
                             names[idx], t_exp[idx], retire_rd_v);
                    bad = 1'b1;
                end
                if (t_opc[idx] == op_ld || t_opc[idx] == op_st) begin
                    if (last_addr !== {t_alu[idx][31:2], 2'b00}) begin
                        $display("Mismatch %s addr expected %h actual %h", names[idx],
                                 {t_alu[idx][31:2], 2'b00}, last_addr);
                        bad = 1'b1;
                    end
                    if (cycle != resp_cyc) begin
                        $display("%s retired %0d cycles after the response instead of 1",
                                 names[idx], cycle - resp_cyc + 1);
                        bad = 1'b1;
                    end
                end
                if (t_opc[idx] == op_st) begin
                    if (last_wmask !== store_mask(idx)) begin
                        $display("Mismatch %s wmask expected %b actual %b",
                                 names[idx], store_mask(idx), last_wmask);
                        bad = 1'b1;
                    end
                    if (last_wdata !== (t_rs2[idx] << {t_alu[idx][1:0], 3'b000})) begin
                        $display("Mismatch %s wdata expected %h actual %h", names[idx],
                                 t_rs2[idx] << {t_alu[idx][1:0], 3'b000}, last_wdata);
                        bad = 1'b1;
                    end
                end else if (t_opc[idx] == op_ld) begin
                    if (last_rmask !== 4'b1111) begin
                        $display("Mismatch %s rmask expected %b actual %b",
                                 names[idx], 4'b1111, last_rmask);
                        bad = 1'b1;
                    end
                end else if (cycle != acc_cyc[idx]) begin
                    $display("%s retired %0d cycles after acceptance instead of 1",
                             names[idx], cycle - acc_cyc[idx] + 1);
                    bad = 1'b1;
                end
                if (dest_of(idx) != 5'd0) ref_regs[dest_of(idx)] = t_exp[idx];
                rs1_s = dest_of(idx);
                chk_name = names[idx];
                chk_pend = 1'b1;
                if (bad) failed++;
                else passed++;
                $display("test %s %s", names[idx], bad ? "failed" : "passed");
                retired++;
            end
        end
    end

    // **************************************************
    // watchdog
    // **************************************************
    initial begin
        #(num_tests * 8 * 40);
        $display("timeout, %0d of %0d instructions retired", retired, num_tests);
        $display("** FAIL **");
        $finish;
    end

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        logic [7:0] wi;
        rst = 1'b1;
        ex_valid = 0;
        ex_inst = 0;
        ex_pc = 0;
        ex_rd_s = 0;
        ex_alu_out = 0;
        ex_br_en = 0;
        ex_u_imm = 0;
        ex_rs2_v = 0;
        ex_mem_read = 0;
        ex_mem_write = 0;
        ex_load_ops = lw_mem;
        ex_store_ops = sw_mem;
        ex_regf_we = 0;
        ex_regf_m_sel = alu_out_wb;
        dmem_resp = 0;
        dmem_rdata = 0;
        rs1_s = 0;
        rs2_s = 0;
        chk_pend = 0;
        chk_name = "";
        busy = 0;
        last_wmask = 0;
        last_wdata = 0;
        last_rmask = 0;
        last_addr = 0;
        for (int i = 0; i < 256; i++) begin
            wi = i[7:0];
            mem[i] = 32'h8f7e_6d5c ^ {4{wi}};
        end
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'h0;
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (ex_ready !== 1'b1 || retire_valid !== 1'b0 || dmem_rmask !== 4'b0 ||
            dmem_wmask !== 4'b0) begin
            $display("outputs after reset are not idle");
            other_errs++;
        end
        check_regs("reset");

        for (int i = 0; i < num_tests; i++) begin
            @(negedge clk);
            ex_valid = 1'b1;
            ex_inst = {20'h0, t_rd[i], t_opc[i]};
            ex_pc = 32'h1000 + 4 * i;
            ex_rd_s = t_rd[i];
            ex_alu_out = t_alu[i];
            ex_br_en = t_br[i];
            ex_u_imm = t_uimm[i];
            ex_rs2_v = t_rs2[i];
            ex_mem_read = (t_opc[i] == op_ld);
            ex_mem_write = (t_opc[i] == op_st);
            ex_load_ops = t_lop[i];
            ex_store_ops = t_sop[i];
            ex_regf_we = 1'b1;
            ex_regf_m_sel = t_sel[i];
            while (!ex_ready) @(negedge clk);  // hold while stalled
            acc_cyc[i] = cycle + 1;
            exp_q.push_back(i);
        end
        @(negedge clk);
        ex_valid = 1'b0;
        while (retired < num_tests) @(negedge clk);
        @(negedge clk);
        check_regs("final");

        $display("tests: %0d passed, %0d failed, %0d other errors", passed, failed, other_errs);
        if (failed == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== src/backend_top.sv ====
`timescale 1ns/10ps

module backend_top (
    input  logic                                      clk,
    input  logic                                      rst,

    // execute stage
    input  logic                                      ex_valid,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_inst,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_pc,
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    ex_rd_s,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_alu_out,
    input  logic                                      ex_br_en,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_u_imm,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_rs2_v,
    input  logic                                      ex_mem_read,
    input  logic                                      ex_mem_write,
    input  rv32i_types_pkg::load_ops_t                ex_load_ops,
    input  rv32i_types_pkg::store_ops_t               ex_store_ops,
    input  logic                                      ex_regf_we,
    input  rv32i_types_pkg::regf_m_sel_t              ex_regf_m_sel,
    output logic                                      ex_ready,

    // data memory
    output logic [rv32i_types_pkg::xlen-1:0]          dmem_addr,
    output logic [rv32i_types_pkg::mask_w-1:0]        dmem_rmask,
    output logic [rv32i_types_pkg::mask_w-1:0]        dmem_wmask,
    output logic [rv32i_types_pkg::xlen-1:0]          dmem_wdata,
    input  logic                                      dmem_resp,
    input  logic [rv32i_types_pkg::xlen-1:0]          dmem_rdata,

    // decode read ports
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    rs1_s,
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    rs2_s,
    output logic [rv32i_types_pkg::xlen-1:0]          rs1_v,
    output logic [rv32i_types_pkg::xlen-1:0]          rs2_v,

    // retire
    output logic                                      retire_valid,
    output logic [rv32i_types_pkg::reg_addr_w-1:0]    retire_rd_s,
    output logic [rv32i_types_pkg::xlen-1:0]          retire_rd_v
);

    import rv32i_types_pkg::*;

    mem_wb_stage_reg_t     mem_wb_stage_reg;
    logic                  move_pipeline;
    logic [reg_addr_w-1:0] wb_rd_s;
    logic [xlen-1:0]       wb_rd_v;
    logic                  wb_regf_we;

    assign ex_ready     = move_pipeline;
    assign retire_valid = wb_regf_we;
    assign retire_rd_s  = wb_rd_s;
    assign retire_rd_v  = wb_rd_v;

    // **************************************************
    // stages
    // **************************************************
    mem_stage mem_stage0 (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_inst(ex_inst), .ex_pc(ex_pc), .ex_rd_s(ex_rd_s),
        .ex_alu_out(ex_alu_out), .ex_br_en(ex_br_en), .ex_u_imm(ex_u_imm),
        .ex_rs2_v(ex_rs2_v), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_load_ops(ex_load_ops), .ex_store_ops(ex_store_ops),
        .ex_regf_we(ex_regf_we), .ex_regf_m_sel(ex_regf_m_sel),
        .dmem_resp(dmem_resp),
        .mem_wb_stage_reg(mem_wb_stage_reg), .move_pipeline(move_pipeline),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask),
        .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata)
    );

    wb_stage wb_stage0 (
        .clk(clk), .rst(rst),
        .mem_wb_stage_reg(mem_wb_stage_reg), .move_pipeline(move_pipeline),
        .dmem_resp(dmem_resp), .dmem_rdata(dmem_rdata),
        .wb_rd_s(wb_rd_s), .wb_rd_v(wb_rd_v), .wb_regf_we(wb_regf_we)
    );

    regfile regfile0 (
        .clk(clk), .rst(rst),
        .we(wb_regf_we), .rd_s(wb_rd_s), .rd_v(wb_rd_v),
        .rs1_s(rs1_s), .rs2_s(rs2_s), .rs1_v(rs1_v), .rs2_v(rs2_v)
    );

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic                                      we,
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    rd_s,
    input  logic [rv32i_types_pkg::xlen-1:0]          rd_v,

    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    rs1_s,
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    rs2_s,
    output logic [rv32i_types_pkg::xlen-1:0]          rs1_v,
    output logic [rv32i_types_pkg::xlen-1:0]          rs2_v
);

    import rv32i_types_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // **************************************************
    // write port
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_s != '0)) begin  // x0 stays zero
            regs[rd_s] <= rd_v;
        end
    end

    // **************************************************
    // read ports
    // **************************************************
    // no bypass, a same-cycle write shows up on the next read
    assign rs1_v = regs[rs1_s];
    assign rs2_v = regs[rs2_s];

endmodule

// ==== src/wb_stage.sv ====
`timescale 1ns/10ps

module wb_stage (
    input  logic                                      clk,
    input  logic                                      rst,

    input  rv32i_types_pkg::mem_wb_stage_reg_t        mem_wb_stage_reg,
    input  logic                                      move_pipeline,

    input  logic                                      dmem_resp,
    input  logic [rv32i_types_pkg::xlen-1:0]          dmem_rdata,

    output logic [rv32i_types_pkg::reg_addr_w-1:0]    wb_rd_s,
    output logic [rv32i_types_pkg::xlen-1:0]          wb_rd_v,
    output logic                                      wb_regf_we
);

    import rv32i_types_pkg::*;

    logic [xlen-1:0] rdata_q;
    logic [1:0]      byte_off;
    logic [7:0]      lane_byte;
    logic [15:0]     lane_half;
    logic            load_signed;
    logic [xlen-1:0] byte_ext;
    logic [xlen-1:0] half_ext;
    logic [6:0]      opcode;
    logic            no_rd;

    // **************************************************
    // load data capture
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (dmem_resp) begin
            rdata_q <= dmem_rdata;  // held until the load retires
        end
    end

    // **************************************************
    // lane extraction
    // **************************************************
    assign byte_off  = mem_wb_stage_reg.mem_addr[1:0];
    assign lane_byte = rdata_q[{byte_off, 3'b000} +: 8];
    assign lane_half = rdata_q[{byte_off[1], 4'b0000} +: 16];

    // lb and lh extend the sign, the unsigned forms fill with zeros
    assign load_signed = (mem_wb_stage_reg.mem_signal.load_ops == lb_mem) ||
                         (mem_wb_stage_reg.mem_signal.load_ops == lh_mem);

    assign byte_ext = {{24{load_signed & lane_byte[7]}}, lane_byte};
    assign half_ext = {{16{load_signed & lane_half[15]}}, lane_half};

    // **************************************************
    // writeback value
    // **************************************************
    always_comb begin
        wb_rd_v = '0;
        case (mem_wb_stage_reg.wb_signal.regf_m_sel)
            alu_out_wb: begin
                wb_rd_v = mem_wb_stage_reg.alu_out;
            end
            br_en_wb: begin
                wb_rd_v = {{(xlen-1){1'b0}}, mem_wb_stage_reg.br_en};
            end
            u_imm_wb: begin
                wb_rd_v = mem_wb_stage_reg.u_imm;
            end
            lw_wb: begin
                wb_rd_v = rdata_q;
            end
            lb_wb, lbu_wb: begin
                wb_rd_v = byte_ext;
            end
            lh_wb, lhu_wb: begin
                wb_rd_v = half_ext;
            end
            pc_plus4_wb: begin
                wb_rd_v = mem_wb_stage_reg.pc + 32'd4;  // jal / jalr link
            end
            default: begin
                wb_rd_v = '0;
            end
        endcase
    end

    // **************************************************
    // destination and write enable
    // **************************************************
    assign opcode = mem_wb_stage_reg.inst[6:0];
    assign no_rd  = (opcode == br_opcode) || (opcode == store_opcode) ||
                    mem_wb_stage_reg.mem_signal.mem_write;

    assign wb_rd_s = no_rd ? '0 : mem_wb_stage_reg.rd_s;

    // fires once, in the cycle the instruction leaves the stage
    assign wb_regf_we = mem_wb_stage_reg.wb_signal.regf_we &&
                        mem_wb_stage_reg.valid && move_pipeline;

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic                                      ex_valid,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_inst,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_pc,
    input  logic [rv32i_types_pkg::reg_addr_w-1:0]    ex_rd_s,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_alu_out,
    input  logic                                      ex_br_en,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_u_imm,
    input  logic [rv32i_types_pkg::xlen-1:0]          ex_rs2_v,
    input  logic                                      ex_mem_read,
    input  logic                                      ex_mem_write,
    input  rv32i_types_pkg::load_ops_t                ex_load_ops,
    input  rv32i_types_pkg::store_ops_t               ex_store_ops,
    input  logic                                      ex_regf_we,
    input  rv32i_types_pkg::regf_m_sel_t              ex_regf_m_sel,

    input  logic                                      dmem_resp,

    output rv32i_types_pkg::mem_wb_stage_reg_t        mem_wb_stage_reg,
    output logic                                      move_pipeline,

    output logic [rv32i_types_pkg::xlen-1:0]          dmem_addr,
    output logic [rv32i_types_pkg::mask_w-1:0]        dmem_rmask,
    output logic [rv32i_types_pkg::mask_w-1:0]        dmem_wmask,
    output logic [rv32i_types_pkg::xlen-1:0]          dmem_wdata
);

    import rv32i_types_pkg::*;

    mem_wb_stage_reg_t stage_d;
    logic [1:0]        byte_off;
    logic [4:0]        lane_shift;
    logic              mem_op;
    logic              req_active;
    logic              resp_seen;

    assign byte_off   = ex_alu_out[1:0];
    assign lane_shift = {byte_off, 3'b000};  // byte offset in bits

    // **************************************************
    // next stage register contents
    // **************************************************
    always_comb begin
        stage_d = '0;
        stage_d.valid    = ex_valid;  // a bubble rides along as valid low
        stage_d.inst     = ex_inst;
        stage_d.pc       = ex_pc;
        stage_d.rd_s     = ex_rd_s;
        stage_d.alu_out  = ex_alu_out;
        stage_d.br_en    = ex_br_en;
        stage_d.u_imm    = ex_u_imm;
        stage_d.mem_addr = ex_alu_out;

        stage_d.mem_signal.mem_read  = ex_mem_read;
        stage_d.mem_signal.mem_write = ex_mem_write;
        stage_d.mem_signal.load_ops  = ex_load_ops;
        stage_d.mem_signal.store_ops = ex_store_ops;
        stage_d.wb_signal.regf_we    = ex_regf_we;
        stage_d.wb_signal.regf_m_sel = ex_regf_m_sel;

        stage_d.mem_rmask = ex_mem_read ? 4'b1111 : 4'b0000;  // whole word, wb picks the lane

        stage_d.mem_wmask = 4'b0000;
        if (ex_mem_write) begin
            case (ex_store_ops)
                sb_mem:  stage_d.mem_wmask = 4'b0001 << byte_off;
                sh_mem:  stage_d.mem_wmask = 4'b0011 << byte_off;
                default: stage_d.mem_wmask = 4'b1111;
            endcase
        end

        stage_d.mem_wdata = ex_rs2_v << lane_shift;
    end

    // **************************************************
    // stage register and response tracking
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_stage_reg.valid <= 1'b0;
        end else if (move_pipeline) begin
            mem_wb_stage_reg <= stage_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_seen <= 1'b0;
        end else if (move_pipeline) begin
            resp_seen <= 1'b0;  // next instruction starts fresh
        end else if (dmem_resp) begin
            resp_seen <= 1'b1;
        end
    end

    assign mem_op = mem_wb_stage_reg.valid &&
                    (mem_wb_stage_reg.mem_signal.mem_read ||
                     mem_wb_stage_reg.mem_signal.mem_write);

    // empty, non-memory, or memory already answered
    assign move_pipeline = !mem_op || resp_seen;

    // **************************************************
    // data memory request
    // **************************************************
    assign req_active = mem_op && !resp_seen;  // drops the cycle after resp

    assign dmem_addr  = {mem_wb_stage_reg.mem_addr[xlen-1:2], 2'b00};
    assign dmem_rmask = req_active ? mem_wb_stage_reg.mem_rmask : '0;
    assign dmem_wmask = req_active ? mem_wb_stage_reg.mem_wmask : '0;
    assign dmem_wdata = mem_wb_stage_reg.mem_wdata;

endmodule

// ==== src/rv32i_types_pkg.sv ====
package rv32i_types_pkg;

    // **************************************************
    // widths
    // **************************************************
    localparam int xlen       = 32;
    localparam int mask_w     = xlen / 8;  // one strobe per byte lane
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;

    // opcodes that never write rd
    localparam logic [6:0] br_opcode    = 7'b1100011;
    localparam logic [6:0] store_opcode = 7'b0100011;

    // **************************************************
    // operation encodings
    // **************************************************
    typedef enum logic [2:0] {
        lb_mem  = 3'b000,
        lbu_mem = 3'b001,
        lh_mem  = 3'b010,
        lhu_mem = 3'b011,
        lw_mem  = 3'b100
    } load_ops_t;

    typedef enum logic [1:0] {
        sb_mem = 2'b00,
        sh_mem = 2'b01,
        sw_mem = 2'b10
    } store_ops_t;

    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        lw_wb       = 4'd3,
        lb_wb       = 4'd4,
        lbu_wb      = 4'd5,
        lh_wb       = 4'd6,
        lhu_wb      = 4'd7,
        pc_plus4_wb = 4'd8
    } regf_m_sel_t;

    // **************************************************
    // control bundles and stage register
    // **************************************************
    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        load_ops_t  load_ops;
        store_ops_t store_ops;
    } mem_signal_t;

    typedef struct packed {
        logic        regf_we;
        regf_m_sel_t regf_m_sel;
    } wb_signal_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       inst;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd_s;
        logic [xlen-1:0]       alu_out;
        logic                  br_en;
        logic [xlen-1:0]       u_imm;
        logic [xlen-1:0]       mem_addr;   // byte address, not aligned
        logic [mask_w-1:0]     mem_rmask;
        logic [mask_w-1:0]     mem_wmask;  // already shifted to the lane
        logic [xlen-1:0]       mem_wdata;  // already shifted to the lane
        mem_signal_t           mem_signal;
        wb_signal_t            wb_signal;
    } mem_wb_stage_reg_t;

endpackage
